// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
        --top-module tb_nbiot_rx_demod -o tb_sim > build.log 2>&1 \
        || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
        || { echo "simulation error, see sim.log"; exit 1; }

grep -q "Regression failed" sim.log \
        && { echo "FAIL, see sim.log"; exit 1; } \
        || { echo "PASS"; exit 0; }

// ==== sim.f ====
verilog/nbiot_rx_pkg.sv
verilog/rx_demap_fsm.sv
verilog/tone_counter.sv
verilog/symbol_buffer.sv
verilog/bit_demapper.sv
verilog/nbiot_rx_demod_top.sv
test/nbiot_rx_demod_asserts.sv
test/tb_nbiot_rx_demod.sv

// ==== test/nbiot_rx_demod_asserts.sv ====
// Demod protocol checks
`timescale 1ns/1ps
`default_nettype none

module nbiot_rx_demod_asserts import nbiot_rx_pkg::*; (
        input wire logic       i_clk,
        input wire logic       i_rst_n,
        input wire logic       i_ready,      // top o_ready
        input wire logic       i_bit_valid,  // top o_bit_valid
        input wire logic       i_sym_done,   // top o_sym_done
        input wire fsm_state_e i_state
);

        //////////////////////////////////////////////////
        // handshake and output framing
        //////////////////////////////////////////////////

        // input side closed while bits stream
        ready_vs_bits: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !(i_ready && i_bit_valid))
                else $error("o_ready and o_bit_valid high in the same cycle");

        // input side opens again right after the last bit
        done_reopens: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_sym_done |=> i_ready)
                else $error("o_ready did not rise after o_sym_done");

        done_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_sym_done |=> !i_sym_done)
                else $error("o_sym_done lasted more than one cycle");

        // a fill never starts straight out of the drain
        fill_open: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (i_state == FILL) |-> $past(i_ready))
                else $error("FSM in FILL after a cycle with o_ready low");

endmodule

bind nbiot_rx_demod_top nbiot_rx_demod_asserts u_asserts (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ready     (o_ready),
        .i_bit_valid (o_bit_valid),
        .i_sym_done  (o_sym_done),
        .i_state     (state)
);

`default_nettype wire

// ==== test/tb_nbiot_rx_demod.sv ====
// Demod back end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_nbiot_rx_demod import nbiot_rx_pkg::*; ();

        localparam int DW            = DATA_WIDTH_DEF;
        localparam int CLK_PERIOD    = 100;
        localparam int RESET_CYCLES  = 16;
        localparam int FIRST_BIT_LAT = 3;  // drain entry, buffer read, demapper register
        localparam int N_RUNS        = 9;  // symbols sent over all tests
        localparam int WATCHDOG_NS   = N_RUNS * (2 * MAX_TONES + MAX_TONES + 20) * CLK_PERIOD
                                       + RESET_CYCLES * CLK_PERIOD;

        logic                 i_clk;
        logic                 i_rst_n;
        logic                 i_valid;
        logic signed [DW-1:0] i_re;
        logic signed [DW-1:0] i_im;
        logic        [1:0]    i_n_sc;
        mod_e                 i_qm;
        logic                 o_ready;
        logic                 o_bit;
        logic                 o_bit_valid;
        logic                 o_sym_done;

        integer               seed;
        int                   err_cnt;
        int                   test_err0;  // error count when the test began
        int                   pass_cnt;
        int                   fail_cnt;
        logic signed [DW-1:0] smp_re [MAX_TONES];
        logic signed [DW-1:0] smp_im [MAX_TONES];
        logic                 exp_bit_q [$];
        logic                 exp_done_q [$];

        // checker state
        int                   cyc;
        int                   last_acc_cyc;
        logic                 in_stream;
        logic                 done_prev;
        logic                 exp_now;
        logic                 exp_done_now;

        nbiot_rx_demod_top #(
                .DATA_WIDTH (DW)
        ) uut (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_valid     (i_valid),
                .i_re        (i_re),
                .i_im        (i_im),
                .i_n_sc      (i_n_sc),
                .i_qm        (i_qm),
                .o_ready     (o_ready),
                .o_bit       (o_bit),
                .o_bit_valid (o_bit_valid),
                .o_sym_done  (o_sym_done)
        );

        always #(CLK_PERIOD / 2) i_clk = ~i_clk;

        //////////////////////////////////////////////////
        // reference model
        //////////////////////////////////////////////////

        function automatic int tone_limit(input logic [1:0] n_sc);
                case (n_sc)
                        NSC_3:   return 3;
                        NSC_6:   return 6;
                        default: return MAX_TONES;  // code 2 and 3
                endcase
        endfunction

        // one bit per negative component, I before Q, tones in arrival order
        function automatic int ref_bits(input logic signed [DW-1:0] re_s [MAX_TONES],
                                        input logic signed [DW-1:0] im_s [MAX_TONES],
                                        input logic [1:0] n_sc, input mod_e qm,
                                        output logic exp_b [2*MAX_TONES]);
                int n;
                int k;
                n = 0;
                for (k = 0; k < tone_limit(n_sc); k++) begin
                        exp_b[n] = (re_s[k] < 0);
                        n++;
                        if (qm == MOD_QPSK) begin
                                exp_b[n] = (im_s[k] < 0);
                                n++;
                        end
                end
                return n;
        endfunction

        function automatic logic signed [DW-1:0] edge_value(input int sel);
                case (sel % 4)
                        0:       return '0;
                        1:       return {1'b1, {(DW-1){1'b0}}};  // most negative
                        2:       return {1'b0, {(DW-1){1'b1}}};  // most positive
                        default: return '1;                      // minus one
                endcase
        endfunction

        //////////////////////////////////////////////////
        // stimulus
        //////////////////////////////////////////////////

        task automatic fill_random();
                int k;
                for (k = 0; k < MAX_TONES; k++) begin
                        smp_re[k] = DW'($random(seed));
                        smp_im[k] = DW'($random(seed));
                end
        endtask

        task automatic fill_edges();
                int k;
                for (k = 0; k < MAX_TONES; k++) begin
                        smp_re[k] = edge_value(k);
                        smp_im[k] = edge_value(k + 1);
                end
        endtask

        task automatic check_idle_outputs();
                assert (o_ready === 1'b1) else begin
                        $display("FAILED o_ready: got %h expected %h", o_ready, 1'b1);
                        err_cnt++;
                end
                assert (o_bit_valid === 1'b0) else begin
                        $display("FAILED o_bit_valid: got %h expected %h", o_bit_valid, 1'b0);
                        err_cnt++;
                end
                assert (o_sym_done === 1'b0) else begin
                        $display("FAILED o_sym_done: got %h expected %h", o_sym_done, 1'b0);
                        err_cnt++;
                end
        endtask

        // called 1 ns after an edge, returns 1 ns after the o_sym_done edge
        task automatic send_symbol(input logic [1:0] n_sc, input mod_e qm, input logic hold);
                logic exp_b [2*MAX_TONES];
                int   n_bits;
                int   k;
                n_bits = ref_bits(smp_re, smp_im, n_sc, qm, exp_b);
                for (k = 0; k < n_bits; k++) begin
                        exp_bit_q.push_back(exp_b[k]);
                        exp_done_q.push_back(k == n_bits - 1);
                end
                k = 0;
                while (k < tone_limit(n_sc)) begin
                        i_valid = 1'b1;
                        i_re    = smp_re[k];
                        i_im    = smp_im[k];
                        i_n_sc  = n_sc;
                        i_qm    = qm;
                        if (o_ready) begin
                                k++;  // taken on the coming edge
                        end else begin
                                assert (k == 0) else begin
                                        $display("o_ready dropped in the middle of a symbol fill");
                                        err_cnt++;
                                end
                        end
                        @(posedge i_clk);
                        #1;
                end
                assert (!o_ready) else begin
                        $display("o_ready still high after the last sample of the symbol");
                        err_cnt++;
                end
                while (!o_sym_done) begin
                        i_valid = hold;
                        if (hold) begin  // junk that must be ignored, i_qm stays put
                                i_re   = DW'($random(seed));
                                i_im   = DW'($random(seed));
                                i_n_sc = 2'($random(seed));
                        end
                        @(posedge i_clk);
                        #1;
                end
                i_valid = 1'b0;
        endtask

        task automatic finish_test(input string name);
                @(posedge i_clk);
                #1;
                assert (exp_bit_q.size() == 0) else begin
                        $display("%0d expected bits never came out", exp_bit_q.size());
                        err_cnt++;
                        exp_bit_q.delete();
                        exp_done_q.delete();
                end
                if (err_cnt == test_err0) begin
                        pass_cnt++;
                        $display("test %s: ok", name);
                end else begin
                        fail_cnt++;
                        $display("test %s: %0d errors", name, err_cnt - test_err0);
                end
                test_err0 = err_cnt;
        endtask

        //////////////////////////////////////////////////
        // output checker
        //////////////////////////////////////////////////

        always @(posedge i_clk) begin
                cyc = cyc + 1;
                if (i_rst_n) begin
                        if (i_valid && o_ready) begin
                                last_acc_cyc = cyc;
                        end
                        if (done_prev) begin
                                assert (o_ready) else begin
                                        $display("o_ready did not rise after o_sym_done");
                                        err_cnt++;
                                end
                        end
                        if (o_bit_valid) begin
                                // valid is set by one edge and seen here on the next
                                if (!in_stream) begin
                                        assert (cyc - last_acc_cyc - 1 == FIRST_BIT_LAT) else begin
                                                $display("first bit came %0d cycles after the last sample",
                                                         cyc - last_acc_cyc - 1);
                                                err_cnt++;
                                        end
                                end
                                assert (exp_bit_q.size() > 0) else begin
                                        $display("bit output while no bit was expected");
                                        err_cnt++;
                                end
                                if (exp_bit_q.size() > 0) begin
                                        exp_now      = exp_bit_q.pop_front();
                                        exp_done_now = exp_done_q.pop_front();
                                        assert (o_bit === exp_now) else begin
                                                $display("FAILED o_bit: got %h expected %h", o_bit, exp_now);
                                                err_cnt++;
                                        end
                                        assert (o_sym_done === exp_done_now) else begin
                                                if (exp_done_now) begin
                                                        $display("o_sym_done missing on the last bit");
                                                end else begin
                                                        $display("o_sym_done came before the last bit");
                                                end
                                                err_cnt++;
                                        end
                                end
                                in_stream = !o_sym_done;
                        end else begin
                                assert (!in_stream) else begin
                                        $display("gap in the bit stream before o_sym_done");
                                        err_cnt++;
                                end
                                assert (!o_sym_done) else begin
                                        $display("o_sym_done high without a valid bit");
                                        err_cnt++;
                                end
                                in_stream = 1'b0;
                        end
                        done_prev = o_sym_done;
                end
        end

        //////////////////////////////////////////////////
        // test sequence
        //////////////////////////////////////////////////

        initial begin
                i_clk        = 1'b0;
                i_rst_n      = 1'b0;
                i_valid      = 1'b0;
                i_re         = '0;
                i_im         = '0;
                i_n_sc       = NSC_12;
                i_qm         = MOD_BPSK;
                seed         = 32'h158e6389;
                err_cnt      = 0;
                test_err0    = 0;
                pass_cnt     = 0;
                fail_cnt     = 0;
                cyc          = 0;
                last_acc_cyc = 0;
                in_stream    = 1'b0;
                done_prev    = 1'b0;
                repeat (RESET_CYCLES) begin
                        @(posedge i_clk);
                        #1;
                        check_idle_outputs();
                end
                i_rst_n = 1'b1;
                repeat (3) begin
                        @(posedge i_clk);
                        #1;
                        check_idle_outputs();
                end
                finish_test("reset state");
                fill_random();
                send_symbol(NSC_12, MOD_QPSK, 1'b0);
                finish_test("qpsk 12 tones");
                fill_random();
                send_symbol(NSC_3, MOD_BPSK, 1'b0);
                finish_test("bpsk 3 tones");
                fill_random();
                send_symbol(NSC_6, MOD_BPSK, 1'b0);
                finish_test("bpsk 6 tones");
                fill_random();
                send_symbol(NSC_12, MOD_QPSK, 1'b1);
                finish_test("valid held during drain");
                fill_edges();
                send_symbol(NSC_12, MOD_QPSK, 1'b0);
                finish_test("edge component values");
                fill_random();
                send_symbol(NSC_6, MOD_QPSK, 1'b0);
                fill_random();
                send_symbol(NSC_3, MOD_QPSK, 1'b0);
                fill_random();
                send_symbol(NSC_12, MOD_BPSK, 1'b0);
                fill_random();
                send_symbol(2'd3, MOD_QPSK, 1'b0);  // code 3 also means 12 tones
                finish_test("back-to-back symbols");
                $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0 && err_cnt == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("timeout, the run did not end within %0d ns", WATCHDOG_NS);
                $display("Regression failed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== verilog/bit_demapper.sv ====
// Hard-decision demapper and bit serializer
`timescale 1ns/1ps
`default_nettype none

module bit_demapper import nbiot_rx_pkg::*; #(
        parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
        input  wire logic                         i_clk,
        input  wire logic                         i_rst_n,
        input  wire logic                         i_load,       // buffer read issued
        input  wire mod_e                         i_qm,
        input  wire logic                         i_last_tone,
        input  wire logic signed [DATA_WIDTH-1:0] i_re,         // registered buffer data
        input  wire logic signed [DATA_WIDTH-1:0] i_im,
        output logic                              o_dm_ready,
        output logic                              o_bit,
        output logic                              o_bit_valid,
        output logic                              o_sym_done
);

        logic load_d;   // buffer data valid this cycle
        logic last_d;
        logic busy;     // a sample is being serialized
        logic phase;    // 0 = I bit, 1 = Q bit
        mod_e qm_q;
        logic last_q;
        logic sign_i;
        logic sign_q;
        logic final_bit;

        //////////////////////////////////////////////////
        // load alignment and serializer state
        //////////////////////////////////////////////////

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        load_d <= 1'b0;
                        last_d <= 1'b0;
                        busy   <= 1'b0;
                        phase  <= 1'b0;
                        qm_q   <= MOD_BPSK;
                        last_q <= 1'b0;
                end else begin
                        load_d <= i_load;
                        last_d <= i_last_tone;
                        if (load_d) begin
                                busy   <= 1'b1;
                                phase  <= 1'b0;
                                qm_q   <= i_qm;
                                last_q <= last_d;
                        end else if (final_bit) begin
                                busy  <= 1'b0;
                                phase <= 1'b0;
                        end else if (busy) begin
                                phase <= 1'b1;  // qpsk, move on to Q
                        end
                end
        end

        // hard decision, negative gives 1
        always_ff @(posedge i_clk) begin
                if (load_d) begin
                        sign_i <= i_re[DATA_WIDTH-1];
                        sign_q <= i_im[DATA_WIDTH-1];
                end
        end

        //////////////////////////////////////////////////
        // outputs
        //////////////////////////////////////////////////

        assign final_bit   = busy && (phase || (qm_q == MOD_BPSK));
        assign o_bit       = phase ? sign_q : sign_i;
        assign o_bit_valid = busy;
        assign o_sym_done  = final_bit && last_q;

        // A load issued now is captured next cycle, which must be the final
        // bit or idle. Stays low across the last tone so the FSM sees
        // ready again only with the final bit of the symbol.
        assign o_dm_ready = !(load_d && (last_d || (i_qm == MOD_QPSK)))
                            && !(busy && last_q && !final_bit);

endmodule

`default_nettype wire

// ==== verilog/nbiot_rx_demod_top.sv ====
// NB-IoT receive demod top level
`timescale 1ns/1ps
`default_nettype none

module nbiot_rx_demod_top import nbiot_rx_pkg::*; #(
        parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
        input  wire logic                         i_clk,
        input  wire logic                         i_rst_n,
        input  wire logic                         i_valid,
        input  wire logic signed [DATA_WIDTH-1:0] i_re,
        input  wire logic signed [DATA_WIDTH-1:0] i_im,
        input  wire logic        [1:0]            i_n_sc,  // 3, 6 or 12 tones
        input  wire mod_e                         i_qm,
        output logic                              o_ready,
        output logic                              o_bit,
        output logic                              o_bit_valid,
        output logic                              o_sym_done
);

        logic                         wr_en;
        logic                         cnt_clear;
        logic                         cnt_step;
        logic                         dm_load;
        logic                         dm_ready;
        logic                         last;
        logic        [TONE_IDX_W-1:0] idx;
        logic signed [DATA_WIDTH-1:0] rd_re;
        logic signed [DATA_WIDTH-1:0] rd_im;
        fsm_state_e                   state;  // observed by protocol checks

        //////////////////////////////////////////////////
        // control
        //////////////////////////////////////////////////

        rx_demap_fsm u_fsm (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_valid     (i_valid),
                .i_last      (last),
                .i_dm_ready  (dm_ready),
                .o_ready     (o_ready),
                .o_wr_en     (wr_en),
                .o_cnt_clear (cnt_clear),
                .o_cnt_step  (cnt_step),
                .o_dm_load   (dm_load),
                .o_state     (state)
        );

        tone_counter u_cnt (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_clear (cnt_clear),
                .i_step  (cnt_step),
                .i_n_sc  (i_n_sc),
                .o_idx   (idx),
                .o_last  (last)
        );

        //////////////////////////////////////////////////
        // datapath
        //////////////////////////////////////////////////

        symbol_buffer #(
                .DATA_WIDTH (DATA_WIDTH)
        ) u_buf (
                .i_clk   (i_clk),
                .i_wr_en (wr_en),
                .i_addr  (idx),
                .i_re    (i_re),
                .i_im    (i_im),
                .o_re    (rd_re),
                .o_im    (rd_im)
        );

        // modulation code goes straight in, captured per sample
        bit_demapper #(
                .DATA_WIDTH (DATA_WIDTH)
        ) u_dmap (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_load      (dm_load),
                .i_qm        (i_qm),
                .i_last_tone (last),
                .i_re        (rd_re),
                .i_im        (rd_im),
                .o_dm_ready  (dm_ready),
                .o_bit       (o_bit),
                .o_bit_valid (o_bit_valid),
                .o_sym_done  (o_sym_done)
        );

endmodule

`default_nettype wire

// ==== verilog/nbiot_rx_pkg.sv ====
// NB-IoT receive demod shared definitions
`default_nettype none

package nbiot_rx_pkg;

        //////////////////////////////////////////////////
        // sample and symbol sizes
        //////////////////////////////////////////////////

        localparam int DATA_WIDTH_DEF = 16;  // one real or imaginary component
        localparam int MAX_TONES      = 12;  // deepest symbol
        localparam int TONE_IDX_W     = 4;   // enough for 0..11

        // tone code as carried on i_n_sc, 2 and 3 both mean twelve tones
        localparam logic [1:0] NSC_3  = 2'd0;
        localparam logic [1:0] NSC_6  = 2'd1;
        localparam logic [1:0] NSC_12 = 2'd2;

        //////////////////////////////////////////////////
        // modulation and control encodings
        //////////////////////////////////////////////////

        // qpsk gives sign of I then sign of Q, bpsk only I
        typedef enum logic {
                MOD_BPSK = 1'b0,
                MOD_QPSK = 1'b1
        } mod_e;

        typedef enum logic [1:0] {
                IDLE  = 2'd0,  // waiting for first sample
                FILL  = 2'd1,  // writing samples into the buffer
                DRAIN = 2'd2,  // feeding the demapper
                FLUSH = 2'd3   // last tone loaded, waiting for its bits
        } fsm_state_e;

endpackage

`default_nettype wire

// ==== verilog/rx_demap_fsm.sv ====
// Symbol fill and drain controller
`timescale 1ns/1ps
`default_nettype none

module rx_demap_fsm import nbiot_rx_pkg::*; (
        input  wire logic       i_clk,
        input  wire logic       i_rst_n,
        input  wire logic       i_valid,
        input  wire logic       i_last,      // counter at final tone
        input  wire logic       i_dm_ready,  // demapper takes data next cycle
        output logic            o_ready,
        output logic            o_wr_en,
        output logic            o_cnt_clear,
        output logic            o_cnt_step,
        output logic            o_dm_load,
        output fsm_state_e      o_state
);

        fsm_state_e state;
        fsm_state_e state_nxt;
        logic       drain_arm;  // low on the first drain cycle only
        logic       accept;

        //////////////////////////////////////////////////
        // state register
        //////////////////////////////////////////////////

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state     <= IDLE;
                        drain_arm <= 1'b0;
                end else begin
                        state     <= state_nxt;
                        drain_arm <= (state == DRAIN);  // FILL always precedes DRAIN
                end
        end

        //////////////////////////////////////////////////
        // handshake and datapath strobes
        //////////////////////////////////////////////////

        // input side is open while collecting a symbol
        assign o_ready = (state == IDLE) || (state == FILL);
        assign accept  = i_valid && o_ready;

        assign o_wr_en     = accept;
        assign o_cnt_clear = (state == IDLE) && i_valid;  // latch tone code with first sample

        // The fill step wraps the index to zero on the final tone, so the
        // first drain cycle only waits and the buffer read starts at tone 0.
        assign o_dm_load  = (state == DRAIN) && drain_arm && i_dm_ready;
        assign o_cnt_step = accept || o_dm_load;

        assign o_state = state;

        //////////////////////////////////////////////////
        // next state
        //////////////////////////////////////////////////

        always_comb begin
                state_nxt = state;
                case (state)
                        IDLE: begin
                                // a symbol has at least three tones
                                if (i_valid) begin
                                        state_nxt = FILL;
                                end
                        end
                        FILL: begin
                                if (i_valid && i_last) begin
                                        state_nxt = DRAIN;
                                end
                        end
                        DRAIN: begin
                                if (o_dm_load && i_last) begin
                                        state_nxt = FLUSH;
                                end
                        end
                        FLUSH: begin
                                // ready comes back on the final bit of the last tone
                                if (i_dm_ready) begin
                                        state_nxt = IDLE;
                                end
                        end
                        default: state_nxt = IDLE;
                endcase
        end

endmodule

`default_nettype wire

// ==== verilog/symbol_buffer.sv ====
// Complex sample store for one symbol
`timescale 1ns/1ps
`default_nettype none

module symbol_buffer import nbiot_rx_pkg::*; #(
        parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
        input  wire logic                         i_clk,
        input  wire logic                         i_wr_en,
        input  wire logic        [TONE_IDX_W-1:0] i_addr,  // shared by write and read
        input  wire logic signed [DATA_WIDTH-1:0] i_re,
        input  wire logic signed [DATA_WIDTH-1:0] i_im,
        output logic signed      [DATA_WIDTH-1:0] o_re,
        output logic signed      [DATA_WIDTH-1:0] o_im
);

        //////////////////////////////////////////////////
        // storage
        //////////////////////////////////////////////////

        logic signed [DATA_WIDTH-1:0] mem_re [MAX_TONES];
        logic signed [DATA_WIDTH-1:0] mem_im [MAX_TONES];

        // write port
        always_ff @(posedge i_clk) begin
                if (i_wr_en) begin
                        mem_re[i_addr] <= i_re;
                        mem_im[i_addr] <= i_im;
                end
        end

        //////////////////////////////////////////////////
        // registered read
        //////////////////////////////////////////////////

        // data shows up the cycle after the address
        always_ff @(posedge i_clk) begin
                o_re <= mem_re[i_addr];
                o_im <= mem_im[i_addr];
        end

endmodule

`default_nettype wire

// ==== verilog/tone_counter.sv ====
// Tone index counter
`timescale 1ns/1ps
`default_nettype none

module tone_counter import nbiot_rx_pkg::*; (
        input  wire logic                  i_clk,
        input  wire logic                  i_rst_n,
        input  wire logic                  i_clear,  // start of symbol
        input  wire logic                  i_step,
        input  wire logic [1:0]            i_n_sc,   // tone code
        output logic      [TONE_IDX_W-1:0] o_idx,
        output logic                       o_last
);

        logic [1:0]            nsc_q;  // code held for the symbol
        logic [TONE_IDX_W-1:0] limit;

        //////////////////////////////////////////////////
        // tone code decode
        //////////////////////////////////////////////////

        always_comb begin
                case (nsc_q)
                        NSC_3:   limit = TONE_IDX_W'(3);
                        NSC_6:   limit = TONE_IDX_W'(6);
                        default: limit = TONE_IDX_W'(MAX_TONES);  // NSC_12 and up
                endcase
        end

        assign o_last = (o_idx == limit - 1'b1);

        //////////////////////////////////////////////////
        // index register
        //////////////////////////////////////////////////

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        nsc_q <= NSC_12;
                        o_idx <= '0;
                end else if (i_clear) begin
                        nsc_q <= i_n_sc;
                        // first sample goes to tone 0 on the same edge
                        o_idx <= {{(TONE_IDX_W-1){1'b0}}, i_step};
                end else if (i_step) begin
                        if (o_last) begin
                                o_idx <= '0;  // wrap, ready for the next pass
                        end else begin
                                o_idx <= o_idx + 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire
